// ==== all.f ====
+incdir+verilog
verilog/stall_pkg.sv
verilog/stall_cfg_regs.sv
verilog/stall_lfsr.sv
verilog/stall_grant_ctrl.sv
verilog/stall_resp_buffer.sv
verilog/stall_resp_ctrl.sv
verilog/stall_injector_top.sv
dv/stall_tb.sv

// ==== dv/stall_tb.sv ====
`timescale 1ns/100ps
`include "stall_settings.svh"

module stall_tb import stall_pkg::*; ();

    // Transactions over all phases and the largest stall ever programmed
    localparam int NUM_TXN   = 182;
    localparam int MAX_STALL = 7;
    localparam int TIMEOUT   = NUM_TXN * (2 * MAX_STALL + 8);
    localparam int MEM_WORDS = 16;

    logic                     clk_i;
    logic                     arst_n_i;
    logic                     req_i;
    mem_req_t                 core_req_i;
    logic                     gnt_o;
    logic                     rvalid_o;
    mem_rsp_t                 core_rsp_o;
    logic                     mem_req_o;
    mem_req_t                 mem_req_o_data;
    logic                     mem_gnt_i;
    logic                     mem_rvalid_i;
    mem_rsp_t                 mem_rsp_i;
    logic                     dbg_we_i;
    stall_reg_e               dbg_sel_i;
    logic [`STALL_DATA_W-1:0] dbg_wdata_i;

    // Input values for the coming cycle
    logic                     nxt_req;
    mem_req_t                 nxt_creq;
    logic                     nxt_gnt;
    logic                     nxt_rvalid;
    mem_rsp_t                 nxt_rsp;
    logic                     nxt_dbg_we;
    stall_reg_e               nxt_dbg_sel;
    logic [`STALL_DATA_W-1:0] nxt_dbg_wdata;

    // Memory model and scoreboard
    integer                   seed;
    int                       cyc;
    logic [`STALL_DATA_W-1:0] mem_words [MEM_WORDS];
    mem_rsp_t                 exp_q [$];
    mem_rsp_t                 rsp_q [$];
    int                       due_q [$];
    int                       cap_q [$];
    int                       last_due;
    int                       gnt_wait;
    int                       idle_wait;
    int                       outstanding;
    int                       grant_cnt;
    int                       rvalid_cnt;
    int                       txn_left;
    int                       req_start;
    bit                       fwd_seen;
    bit                       serial_mode;
    bit                       fast_mem;

    // Expected configuration
    stall_mode_e             cur_mode;
    logic [`STALL_CNT_W-1:0] cur_gnt;
    logic [`STALL_CNT_W-1:0] cur_valid;
    logic [`STALL_CNT_W-1:0] cur_mask;

    stall_injector_top u_stall_injector_top (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .req_i          (req_i),
        .core_req_i     (core_req_i),
        .gnt_o          (gnt_o),
        .rvalid_o       (rvalid_o),
        .core_rsp_o     (core_rsp_o),
        .mem_req_o      (mem_req_o),
        .mem_req_o_data (mem_req_o_data),
        .mem_gnt_i      (mem_gnt_i),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rsp_i      (mem_rsp_i),
        .dbg_we_i       (dbg_we_i),
        .dbg_sel_i      (dbg_sel_i),
        .dbg_wdata_i    (dbg_wdata_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    ////////////////////
    // Reporting
    ////////////////////

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "Run stopped at cycle %0d", cyc);
    endtask

    task automatic check_rsp(input string name, input mem_rsp_t got, input mem_rsp_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    // Random stall never above the programmed mask
    task automatic check_bound(input string name, input int got, input int limit);
        if (got > limit) begin
            stop_run($sformatf("Fail %s got %h above limit %h", name, got, limit));
        end
    endtask

    ////////////////////
    // Models
    ////////////////////

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic int word_index(input logic [`STALL_ADDR_W-1:0] addr);
        return int'(addr >> 2) % MEM_WORDS;
    endfunction

    // Small address window so reads hit earlier writes
    function automatic mem_req_t random_req();
        mem_req_t r;
        r.addr  = `STALL_ADDR_W'(rand_range(0, MEM_WORDS - 1) * 4);
        r.we    = rand_range(0, 1) == 1;
        r.be    = (`STALL_DATA_W/8)'($random(seed));
        r.wdata = $random(seed);
        return r;
    endfunction

    // Byte enables select the lanes written
    function automatic void mem_write(input mem_req_t r);
        int idx;
        idx = word_index(r.addr);
        for (int b = 0; b < `STALL_DATA_W/8; b++) begin
            if (r.be[b]) begin
                mem_words[idx][b*8 +: 8] = r.wdata[b*8 +: 8];
            end
        end
    endfunction

    // Observe one cycle at the falling edge and plan the next inputs
    task automatic sample_cycle;
        mem_rsp_t rd;
        int       due;
        int       rsp_delay;
        // Request path
        check_bit("gnt_o", gnt_o, mem_req_o & mem_gnt_i);
        if (mem_req_o) begin
            if (!req_i) begin
                stop_run("Memory request forwarded while the core was not requesting");
            end
            check_req("mem_req_o_data", mem_req_o_data, core_req_i);
        end
        if (cur_mode == MODE_OFF && outstanding < `STALL_MAX_OUTST) begin
            check_bit("mem_req_o", mem_req_o, req_i);
        end
        // Grant stall, measured to the first forwarded cycle
        if (mem_req_o && !fwd_seen) begin
            fwd_seen = 1'b1;
            if (serial_mode && cur_mode == MODE_FIXED) begin
                check_count("grant_stall", cyc - req_start, int'(cur_gnt));
            end
            if (serial_mode && cur_mode == MODE_RANDOM) begin
                check_bound("grant_stall", cyc - req_start, int'(cur_mask));
            end
        end
        // Memory response going out this cycle
        if (mem_rvalid_i) begin
            void'(rsp_q.pop_front());
            void'(due_q.pop_front());
            cap_q.push_back(cyc);
        end
        // Handshake, memory answers in order one to three cycles later
        if (gnt_o) begin
            if (core_req_i.we) begin
                mem_write(core_req_i);
                rd.rdata = '0;
            end else begin
                rd.rdata = mem_words[word_index(core_req_i.addr)];
            end
            due = cyc + rand_range(1, 3);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            rsp_q.push_back(rd);
            due_q.push_back(due);
            exp_q.push_back(rd);
            grant_cnt++;
            outstanding++;
            gnt_wait  = fast_mem ? 0 : rand_range(0, 2);
            idle_wait = rand_range(0, 1);
        end else if (mem_req_o && gnt_wait > 0) begin
            gnt_wait--;
        end
        // Response at the core
        if (rvalid_o) begin
            if (exp_q.size() == 0) begin
                stop_run("Response strobe with no transaction outstanding");
            end
            check_rsp("core_rsp_o", core_rsp_o, exp_q.pop_front());
            rsp_delay = cyc - cap_q.pop_front();
            if (serial_mode && cur_mode == MODE_FIXED) begin
                check_count("rvalid_delay", rsp_delay, int'(cur_valid) + 1);
            end
            if (serial_mode && cur_mode == MODE_RANDOM) begin
                check_bound("rvalid_stall", rsp_delay - 1, int'(cur_mask));
            end
            rvalid_cnt++;
            outstanding--;
        end
        // Memory drive, junk data while idle
        nxt_gnt    = (gnt_wait == 0);
        nxt_rvalid = (due_q.size() > 0) && (due_q[0] <= cyc + 1);
        if (nxt_rvalid) begin
            nxt_rsp = rsp_q[0];
        end else begin
            nxt_rsp.rdata = $random(seed);
        end
        // Core holds its request until granted
        if (req_i && !gnt_o) begin
            nxt_req = 1'b1;
        end else if (txn_left > 0 && idle_wait == 0 && (!serial_mode || outstanding == 0)) begin
            nxt_req   = 1'b1;
            nxt_creq  = random_req();
            req_start = cyc + 1;
            fwd_seen  = 1'b0;
            txn_left--;
        end else begin
            nxt_req = 1'b0;
            if (idle_wait > 0) begin
                idle_wait--;
            end
        end
    endtask

    task automatic run_cycle;
        @(negedge clk_i);
        sample_cycle();
        @(posedge clk_i);
        cyc++;
        if (cyc > TIMEOUT) begin
            stop_run($sformatf("Timeout after %0d cycles with %0d responses outstanding",
                               cyc, outstanding));
        end
        #1;
        req_i        = nxt_req;
        core_req_i   = nxt_creq;
        mem_gnt_i    = nxt_gnt;
        mem_rvalid_i = nxt_rvalid;
        mem_rsp_i    = nxt_rsp;
        dbg_we_i     = nxt_dbg_we;
        dbg_sel_i    = nxt_dbg_sel;
        dbg_wdata_i  = nxt_dbg_wdata;
    endtask

    // One cycle write strobe, fields keep their low bits
    task automatic write_reg(input stall_reg_e sel, input logic [`STALL_DATA_W-1:0] val);
        nxt_dbg_we    = 1'b1;
        nxt_dbg_sel   = sel;
        nxt_dbg_wdata = val;
        run_cycle();
        nxt_dbg_we = 1'b0;
        run_cycle();
        case (sel)
            REG_MODE: begin
                if (val[1:0] != 2'd3) begin
                    cur_mode = stall_mode_e'(val[1:0]);
                end
            end
            REG_GNT_STALL:   cur_gnt   = val[`STALL_CNT_W-1:0];
            REG_VALID_STALL: cur_valid = val[`STALL_CNT_W-1:0];
            default:         cur_mask  = val[`STALL_CNT_W-1:0];
        endcase
    endtask

    // Issue n transactions and drain every response
    task automatic run_phase(input int n, input bit serial, input bit fast);
        txn_left    = n;
        serial_mode = serial;
        fast_mem    = fast;
        gnt_wait    = 0;
        while (txn_left > 0 || req_i || outstanding > 0) begin
            run_cycle();
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        seed         = 32'hff83;
        arst_n_i     = 1'b0;
        req_i        = 1'b0;
        core_req_i   = '0;
        mem_gnt_i    = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rsp_i    = '0;
        dbg_we_i     = 1'b0;
        dbg_sel_i    = REG_MODE;
        dbg_wdata_i  = '0;
        nxt_req       = 1'b0;
        nxt_creq      = '0;
        nxt_gnt       = 1'b0;
        nxt_rvalid    = 1'b0;
        nxt_rsp       = '0;
        nxt_dbg_we    = 1'b0;
        nxt_dbg_sel   = REG_MODE;
        nxt_dbg_wdata = '0;
        cyc         = 0;
        last_due    = 0;
        gnt_wait    = 0;
        idle_wait   = 0;
        outstanding = 0;
        grant_cnt   = 0;
        rvalid_cnt  = 0;
        txn_left    = 0;
        req_start   = 0;
        fwd_seen    = 1'b0;
        serial_mode = 1'b0;
        fast_mem    = 1'b0;
        cur_mode    = MODE_OFF;
        cur_gnt     = '0;
        cur_valid   = '0;
        cur_mask    = '0;
        // Fill pattern from the byte address
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = 32'hc3a5_0000 ^ ((i * 4) * 32'h0001_0101);
        end
        repeat (4) @(posedge clk_i);
        // Outputs quiet under reset
        @(negedge clk_i);
        check_bit("gnt_o", gnt_o, 1'b0);
        check_bit("rvalid_o", rvalid_o, 1'b0);
        check_bit("mem_req_o", mem_req_o, 1'b0);
        repeat (4) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;

        // Off mode with overlapped traffic
        run_phase(40, 1'b0, 1'b0);
        // Fixed mode, one at a time, upper write bits dropped
        write_reg(REG_GNT_STALL, 32'h0000_ff03);
        write_reg(REG_VALID_STALL, 32'd2);
        write_reg(REG_MODE, MODE_FIXED);
        // Unused mode code 3 leaves fixed mode in place
        write_reg(REG_MODE, 32'd3);
        run_phase(12, 1'b1, 1'b1);
        // Fixed mode overlapped
        write_reg(REG_GNT_STALL, 32'd1);
        write_reg(REG_VALID_STALL, 32'd4);
        run_phase(40, 1'b0, 1'b0);
        // Random mode, stalls bounded by the mask
        write_reg(REG_RAND_MASK, 32'd7);
        write_reg(REG_MODE, MODE_RANDOM);
        run_phase(30, 1'b1, 1'b0);
        write_reg(REG_RAND_MASK, 32'd3);
        run_phase(40, 1'b0, 1'b0);
        // Back to off
        write_reg(REG_MODE, MODE_OFF);
        run_phase(20, 1'b0, 1'b0);

        // Idle tail so a stray response strobe still gets caught
        repeat (2 * MAX_STALL + 8) begin
            run_cycle();
        end
        check_count("grant_count", grant_cnt, NUM_TXN);
        if (rvalid_cnt != NUM_TXN) begin
            stop_run($sformatf("Fail rvalid_count got %h expected %h", rvalid_cnt, NUM_TXN));
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// ==== verilog/stall_injector_top.sv ====
`timescale 1ns/100ps
`include "stall_settings.svh"

module stall_injector_top import stall_pkg::*; (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // Core side
    input  logic                     req_i,
    input  mem_req_t                 core_req_i,
    output logic                     gnt_o,
    output logic                     rvalid_o,
    output mem_rsp_t                 core_rsp_o,
    // Memory side
    output logic                     mem_req_o,
    output mem_req_t                 mem_req_o_data,
    input  logic                     mem_gnt_i,
    input  logic                     mem_rvalid_i,
    input  mem_rsp_t                 mem_rsp_i,
    // Debug register port
    input  logic                     dbg_we_i,
    input  stall_reg_e               dbg_sel_i,
    input  logic [`STALL_DATA_W-1:0] dbg_wdata_i
);

    stall_cfg_t              cfg;
    logic                    rand_step;
    logic [`STALL_CNT_W-1:0] rand_val;
    logic                    push;
    logic [`STALL_CNT_W-1:0] push_stall;
    logic                    buf_full;
    resp_entry_t             head;
    logic                    head_valid;
    logic                    pop;

    ////////////////////
    // Configuration
    ////////////////////

    stall_cfg_regs u_stall_cfg_regs (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .dbg_we_i    (dbg_we_i),
        .dbg_sel_i   (dbg_sel_i),
        .dbg_wdata_i (dbg_wdata_i),
        .cfg_o       (cfg)
    );

    // Random stall source
    stall_lfsr u_stall_lfsr (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .step_i   (rand_step),
        .val_o    (rand_val)
    );

    ////////////////////
    // Request path
    ////////////////////

    stall_grant_ctrl u_stall_grant_ctrl (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .cfg_i          (cfg),
        .rand_val_i     (rand_val),
        .rand_step_o    (rand_step),
        .req_i          (req_i),
        .core_req_i     (core_req_i),
        .gnt_o          (gnt_o),
        .mem_req_o      (mem_req_o),
        .mem_req_data_o (mem_req_o_data),
        .mem_gnt_i      (mem_gnt_i),
        .buf_full_i     (buf_full),
        .push_o         (push),
        .push_stall_o   (push_stall)
    );

    ////////////////////
    // Response path
    ////////////////////

    stall_resp_buffer u_stall_resp_buffer (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .push_i       (push),
        .push_stall_i (push_stall),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rsp_i    (mem_rsp_i),
        .pop_i        (pop),
        .head_o       (head),
        .head_valid_o (head_valid),
        .full_o       (buf_full)
    );

    stall_resp_ctrl u_stall_resp_ctrl (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .head_i       (head),
        .head_valid_i (head_valid),
        .pop_o        (pop),
        .rvalid_o     (rvalid_o),
        .core_rsp_o   (core_rsp_o)
    );

endmodule

// ==== verilog/stall_resp_ctrl.sv ====
`timescale 1ns/100ps
`include "stall_settings.svh"

module stall_resp_ctrl import stall_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  resp_entry_t head_i,
    input  logic        head_valid_i,
    output logic        pop_o,
    output logic        rvalid_o,
    output mem_rsp_t    core_rsp_o
);

    rsp_state_e              state_q;
    rsp_state_e              state_d;
    logic [`STALL_CNT_W-1:0] cnt_q;
    logic [`STALL_CNT_W-1:0] cnt_d;

    // Head entry is present and its data is in
    logic head_ready;

    logic     rvalid_q;
    mem_rsp_t rsp_q;

    assign head_ready = head_valid_i && head_i.data_ok;

    ////////////////////
    // FSM
    ////////////////////

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        pop_o   = 1'b0;
        case (state_q)
            WAIT: begin
                if (head_ready) begin
                    // Zero stall goes out on the next edge
                    if (head_i.stall == '0) begin
                        pop_o = 1'b1;
                    end else begin
                        state_d = COUNT;
                        cnt_d   = head_i.stall - 1'b1;
                    end
                end
            end
            COUNT: begin
                // Head stays put until popped here
                if (cnt_q == '0) begin
                    pop_o   = 1'b1;
                    state_d = WAIT;
                end else begin
                    cnt_d = cnt_q - 1'b1;
                end
            end
            default: begin
                state_d = WAIT;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= WAIT;
            cnt_q    <= '0;
            rvalid_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            cnt_q    <= cnt_d;
            // One cycle strobe per popped entry
            rvalid_q <= pop_o;
        end
    end

    // Read data lines up with the strobe
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            rsp_q <= head_i.rsp;
        end
    end

    assign rvalid_o   = rvalid_q;
    assign core_rsp_o = rsp_q;

endmodule

// ==== verilog/stall_resp_buffer.sv ====
`timescale 1ns/100ps
`include "stall_settings.svh"

module stall_resp_buffer import stall_pkg::*; (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    push_i,
    input  logic [`STALL_CNT_W-1:0] push_stall_i,
    input  logic                    mem_rvalid_i,
    input  mem_rsp_t                mem_rsp_i,
    input  logic                    pop_i,
    output resp_entry_t             head_o,
    output logic                    head_valid_o,
    output logic                    full_o
);

    localparam int DEPTH = `STALL_MAX_OUTST;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int OCC_W = $clog2(DEPTH + 1);

    // Entry storage
    logic [`STALL_CNT_W-1:0] stall_mem [DEPTH];
    mem_rsp_t                rsp_mem   [DEPTH];
    logic [DEPTH-1:0]        ok_q;

    // Write, capture and read pointers plus occupancy
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] cap_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [OCC_W-1:0] count_q;

    // Wrap at depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end else begin
            return ptr + 1'b1;
        end
    endfunction

    // Payload writes
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            stall_mem[wr_ptr_q] <= push_stall_i;
        end
        // Responses come back in order, oldest open entry first
        if (mem_rvalid_i) begin
            rsp_mem[cap_ptr_q] <= mem_rsp_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ok_q      <= '0;
            wr_ptr_q  <= '0;
            cap_ptr_q <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
        end else begin
            // New entry starts without data
            if (push_i) begin
                ok_q[wr_ptr_q] <= 1'b0;
                wr_ptr_q       <= ptr_inc(wr_ptr_q);
            end
            if (mem_rvalid_i) begin
                ok_q[cap_ptr_q] <= 1'b1;
                cap_ptr_q       <= ptr_inc(cap_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push_i, pop_i})
                2'b10: begin
                    count_q <= count_q + 1'b1;
                end
                2'b01: begin
                    count_q <= count_q - 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    assign head_valid_o = (count_q != '0);
    assign full_o       = (count_q == OCC_W'(DEPTH));

    // Head sees arriving data in the capture cycle itself
    // An open head is always the one the memory answers
    always_comb begin
        head_o.stall   = stall_mem[rd_ptr_q];
        head_o.data_ok = ok_q[rd_ptr_q] | mem_rvalid_i;
        head_o.rsp     = ok_q[rd_ptr_q] ? rsp_mem[rd_ptr_q] : mem_rsp_i;
    end

endmodule

// ==== verilog/stall_grant_ctrl.sv ====
`timescale 1ns/100ps
`include "stall_settings.svh"

module stall_grant_ctrl import stall_pkg::*; (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  stall_cfg_t              cfg_i,
    input  logic [`STALL_CNT_W-1:0] rand_val_i,
    output logic                    rand_step_o,
    input  logic                    req_i,
    input  mem_req_t                core_req_i,
    output logic                    gnt_o,
    output logic                    mem_req_o,
    output mem_req_t                mem_req_data_o,
    input  logic                    mem_gnt_i,
    input  logic                    buf_full_i,
    output logic                    push_o,
    output logic [`STALL_CNT_W-1:0] push_stall_o
);

    gnt_state_e              state_q;
    gnt_state_e              state_d;
    logic [`STALL_CNT_W-1:0] cnt_q;
    logic [`STALL_CNT_W-1:0] cnt_d;

    // Stall values picked for the current mode
    logic [`STALL_CNT_W-1:0] rand_cnt;
    logic [`STALL_CNT_W-1:0] gnt_stall;
    logic [`STALL_CNT_W-1:0] rsp_stall;

    logic fwd_en;
    logic handshake;
    logic draw_gnt;

    ////////////////////
    // Stall selection
    ////////////////////

    // Random draws never exceed the programmed mask
    assign rand_cnt = rand_val_i & cfg_i.rand_mask;

    always_comb begin
        case (cfg_i.mode)
            MODE_FIXED: begin
                gnt_stall = cfg_i.gnt_stall;
                rsp_stall = cfg_i.valid_stall;
            end
            MODE_RANDOM: begin
                gnt_stall = rand_cnt;
                rsp_stall = rand_cnt;
            end
            default: begin
                gnt_stall = '0;
                rsp_stall = '0;
            end
        endcase
    end

    ////////////////////
    // Forwarding
    ////////////////////

    // A zero stall forwards in the very cycle the request shows up
    always_comb begin
        case (state_q)
            IDLE: begin
                fwd_en = (gnt_stall == '0);
            end
            STALL: begin
                fwd_en = (cnt_q == '0);
            end
            FORWARD: begin
                fwd_en = 1'b1;
            end
            default: begin
                fwd_en = 1'b0;
            end
        endcase
    end

    // Hold off while every response slot is taken
    assign mem_req_o      = req_i && fwd_en && !buf_full_i;
    assign mem_req_data_o = core_req_i;
    assign handshake      = mem_req_o && mem_gnt_i;
    assign gnt_o          = handshake;

    // Reserve the response slot right at the handshake
    assign push_o       = handshake;
    assign push_stall_o = rsp_stall;

    // One LFSR step per count drawn from it
    assign draw_gnt    = (state_q == IDLE) && req_i;
    assign rand_step_o = (cfg_i.mode == MODE_RANDOM) && (draw_gnt || handshake);

    ////////////////////
    // FSM
    ////////////////////

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            IDLE: begin
                // A granted zero stall request is already done
                if (req_i && !handshake) begin
                    if (gnt_stall == '0) begin
                        state_d = FORWARD;
                    end else begin
                        state_d = STALL;
                        cnt_d   = gnt_stall - 1'b1;
                    end
                end
            end
            STALL: begin
                if (cnt_q != '0) begin
                    cnt_d = cnt_q - 1'b1;
                end else if (handshake) begin
                    state_d = IDLE;
                end else begin
                    state_d = FORWARD;
                end
            end
            FORWARD: begin
                // Memory back-pressure just keeps us here
                if (handshake) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

endmodule

// ==== verilog/stall_lfsr.sv ====
`timescale 1ns/100ps
`include "stall_settings.svh"

module stall_lfsr (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    step_i,
    output logic [`STALL_CNT_W-1:0] val_o
);

    // Feedback taps for x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [15:0] TAPS = 16'hB400;

    logic [15:0] lfsr_q;
    logic [15:0] lfsr_next;

    // Galois form, shift right and fold the output bit into the taps
    always_comb begin
        lfsr_next = {1'b0, lfsr_q[15:1]};
        if (lfsr_q[0]) begin
            lfsr_next = lfsr_next ^ TAPS;
        end
    end

    // Only moves when a random count is drawn
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lfsr_q <= `STALL_LFSR_SEED;
        end else if (step_i) begin
            lfsr_q <= lfsr_next;
        end
    end

    // Low bits serve as the raw stall count
    assign val_o = lfsr_q[`STALL_CNT_W-1:0];

endmodule

// ==== verilog/stall_cfg_regs.sv ====
`timescale 1ns/100ps
`include "stall_settings.svh"

module stall_cfg_regs import stall_pkg::*; (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     dbg_we_i,
    input  stall_reg_e               dbg_sel_i,
    input  logic [`STALL_DATA_W-1:0] dbg_wdata_i,
    output stall_cfg_t               cfg_o
);

    // Mode field of the write data
    logic [1:0] mode_wr;

    // Set for encodings that name a real mode
    logic       mode_legal;

    assign mode_wr = dbg_wdata_i[1:0];

    always_comb begin
        case (mode_wr)
            MODE_OFF, MODE_FIXED, MODE_RANDOM: begin
                mode_legal = 1'b1;
            end
            default: begin
                mode_legal = 1'b0;
            end
        endcase
    end

    ////////////////////
    // Register bank
    ////////////////////

    // Write only, each field keeps the low bits of the write
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // Come up with no stalls at all
            cfg_o.mode        <= MODE_OFF;
            cfg_o.gnt_stall   <= '0;
            cfg_o.valid_stall <= '0;
            cfg_o.rand_mask   <= '0;
        end else if (dbg_we_i) begin
            case (dbg_sel_i)
                REG_MODE: begin
                    // Undefined mode codes are dropped
                    if (mode_legal) begin
                        cfg_o.mode <= stall_mode_e'(mode_wr);
                    end
                end
                REG_GNT_STALL: begin
                    cfg_o.gnt_stall <= dbg_wdata_i[`STALL_CNT_W-1:0];
                end
                REG_VALID_STALL: begin
                    cfg_o.valid_stall <= dbg_wdata_i[`STALL_CNT_W-1:0];
                end
                REG_RAND_MASK: begin
                    cfg_o.rand_mask <= dbg_wdata_i[`STALL_CNT_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== verilog/stall_pkg.sv ====
`include "stall_settings.svh"

package stall_pkg;

    // Stall modes
    typedef enum logic [1:0] {
        MODE_OFF    = 2'd0,
        MODE_FIXED  = 2'd1,
        MODE_RANDOM = 2'd2
    } stall_mode_e;

    // Debug register select
    typedef enum logic [1:0] {
        REG_MODE        = 2'd0,
        REG_GNT_STALL   = 2'd1,
        REG_VALID_STALL = 2'd2,
        REG_RAND_MASK   = 2'd3
    } stall_reg_e;

    // Grant side FSM
    typedef enum logic [1:0] {
        IDLE,
        STALL,
        FORWARD
    } gnt_state_e;

    // Response side FSM
    typedef enum logic {
        WAIT,
        COUNT
    } rsp_state_e;

    // Request as the core presents it
    typedef struct packed {
        logic [`STALL_ADDR_W-1:0]   addr;
        logic                       we;
        logic [`STALL_DATA_W/8-1:0] be;
        logic [`STALL_DATA_W-1:0]   wdata;
    } mem_req_t;

    // Response payload
    typedef struct packed {
        logic [`STALL_DATA_W-1:0] rdata;
    } mem_rsp_t;

    // Programmed configuration
    typedef struct packed {
        stall_mode_e             mode;
        logic [`STALL_CNT_W-1:0] gnt_stall;
        logic [`STALL_CNT_W-1:0] valid_stall;
        logic [`STALL_CNT_W-1:0] rand_mask;
    } stall_cfg_t;

    // One outstanding transaction in the response buffer
    typedef struct packed {
        logic [`STALL_CNT_W-1:0] stall;
        logic                    data_ok;
        mem_rsp_t                rsp;
    } resp_entry_t;

endpackage

// ==== verilog/stall_settings.svh ====
`ifndef STALL_SETTINGS_SVH
`define STALL_SETTINGS_SVH

////////////////////
// Bus geometry
////////////////////

// Address and data width, same on the core and the memory side
`define STALL_ADDR_W 32
`define STALL_DATA_W 32

////////////////////
// Stall engine
////////////////////

// Response buffer depth and the outstanding transaction limit
`define STALL_MAX_OUTST 4

// Stall counters and the stall fields of the configuration
`define STALL_CNT_W 8

// LFSR start value
// An all zero state never leaves zero, so keep this nonzero
`define STALL_LFSR_SEED 16'hACE1

`endif
